/* design/core_types_pkg.sv */
/*
  Shared widths, data typedefs, ALU op encodings,
  and the issue and writeback structs of the immediate ALU lane
*/
package core_types_pkg;

  // Defaults; the top level passes counts that must match these
  localparam int DEF_PRF_BANK_COUNT = 2;
  localparam int DEF_PR_COUNT       = 64;
  localparam int DEF_ROB_ENTRIES    = 16;

  typedef logic [31:0] word_t;
  typedef logic [11:0] imm12_t;
  typedef logic [3:0]  alu_op_t;

  typedef logic [$clog2(DEF_PR_COUNT)-1:0]    pr_t;
  typedef logic [$clog2(DEF_ROB_ENTRIES)-1:0] rob_idx_t;

  // Op codes, loosely following the RISC-V funct3 layout
  localparam alu_op_t OP_ADDI  = 4'h0;
  localparam alu_op_t OP_SLLI  = 4'h1;
  localparam alu_op_t OP_SLTI  = 4'h2;
  localparam alu_op_t OP_SLTIU = 4'h3;
  localparam alu_op_t OP_XORI  = 4'h4;
  localparam alu_op_t OP_SRLI  = 4'h5;
  localparam alu_op_t OP_ORI   = 4'h6;
  localparam alu_op_t OP_ANDI  = 4'h7;
  localparam alu_op_t OP_SRAI  = 4'hd;

  // Issued instruction; the source bank is the low bits of A_PR
  typedef struct packed {
    alu_op_t  op;
    imm12_t   imm12;
    logic     A_forward;
    logic     A_is_zero;
    pr_t      A_PR;
    pr_t      dest_PR;
    rob_idx_t ROB_index;
  } issue_t;

  // Writeback payload, qualified by WB_valid
  typedef struct packed {
    word_t    data;
    pr_t      PR;
    rob_idx_t ROB_index;
  } wb_t;

endpackage

/* design/prf_banks.sv */
/*
  Banked physical register file: registered read port,
  writeback write port and one forward bus per bank
*/
module prf_banks #(
  parameter int PRF_BANK_COUNT = core_types_pkg::DEF_PRF_BANK_COUNT,
  parameter int PR_COUNT       = core_types_pkg::DEF_PR_COUNT
) (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  logic                                        read_en,
  input  logic [$clog2(PR_COUNT)-1:0]                 read_PR,
  output core_types_pkg::word_t                       read_data,
  input  logic                                        write_en,
  input  logic [$clog2(PR_COUNT)-1:0]                 write_PR,
  input  core_types_pkg::word_t                       write_data,
  output core_types_pkg::word_t [PRF_BANK_COUNT-1:0]  forward_data_by_bank
);
  import core_types_pkg::*;

  localparam int LOG_PR     = $clog2(PR_COUNT);
  localparam int LOG_BANKS  = $clog2(PRF_BANK_COUNT);
  localparam int BANK_DEPTH = PR_COUNT / PRF_BANK_COUNT;
  localparam int LOG_DEPTH  = $clog2(BANK_DEPTH);

  word_t regs [PRF_BANK_COUNT][BANK_DEPTH];

  logic [LOG_BANKS-1:0] read_bank;
  logic [LOG_DEPTH-1:0] read_row;
  logic [LOG_BANKS-1:0] write_bank;
  logic [LOG_DEPTH-1:0] write_row;

  // Low PR bits pick the bank, the rest pick the row inside it
  assign read_bank  = read_PR[LOG_BANKS-1:0];
  assign read_row   = read_PR[LOG_PR-1:LOG_BANKS];
  assign write_bank = write_PR[LOG_BANKS-1:0];
  assign write_row  = write_PR[LOG_PR-1:LOG_BANKS];

  // Whole file comes out of reset as zero
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int b = 0; b < PRF_BANK_COUNT; b++) begin
        for (int r = 0; r < BANK_DEPTH; r++) begin
          regs[b][r] <= '0;
        end
      end
    end else if (write_en) begin
      regs[write_bank][write_row] <= write_data;
    end
  end

  // Read port 0; value holds while read_en is low
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      read_data <= '0;
    end else if (read_en) begin
      read_data <= regs[read_bank][read_row];
    end
  end

  // A bank's bus shows its write in the write cycle, zero otherwise
  always_comb begin
    for (int b = 0; b < PRF_BANK_COUNT; b++) begin
      if (write_en && write_bank == LOG_BANKS'(b)) begin
        forward_data_by_bank[b] = write_data;
      end else begin
        forward_data_by_bank[b] = '0;
      end
    end
  end

endmodule

/* design/alu_imm_operand_collect.sv */
/*
  Stage-2 register of the immediate ALU lane and the
  per-bank forward bus select for the A operand
*/
module alu_imm_operand_collect #(
  parameter int PRF_BANK_COUNT = core_types_pkg::DEF_PRF_BANK_COUNT
) (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  logic                                        advance,
  input  logic                                        in_valid,
  input  core_types_pkg::issue_t                      in_issue,
  input  core_types_pkg::word_t [PRF_BANK_COUNT-1:0]  forward_data_by_bank,
  output logic                                        out_valid,
  output core_types_pkg::issue_t                      out_issue,
  output core_types_pkg::word_t                       A_forward_data
);

  localparam int LOG_BANKS = $clog2(PRF_BANK_COUNT);

  logic [LOG_BANKS-1:0] a_bank;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance && in_valid) begin
      out_issue <= in_issue;
    end
  end

  assign a_bank = out_issue.A_PR[LOG_BANKS-1:0];

  // The producer sits in WB right ahead of this stage. Its write to the
  // PRF happens in the very cycle this stage advances, so the bus is
  // taken from the live forward bus of the source bank
  always_comb begin
    if (out_valid && out_issue.A_forward) begin
      A_forward_data = forward_data_by_bank[a_bank];
    end else begin
      A_forward_data = '0;
    end
  end

endmodule

/* design/imm_alu.sv */
/*
  Combinational ALU for the immediate integer ops
*/
module imm_alu (
  input  core_types_pkg::alu_op_t op,
  input  core_types_pkg::word_t   A,
  input  core_types_pkg::imm12_t  imm12,
  output core_types_pkg::word_t   result
);
  import core_types_pkg::*;

  word_t      imm;
  logic [4:0] shamt;

  assign imm   = {{20{imm12[11]}}, imm12};
  assign shamt = imm12[4:0];

  // SRAI is its own op code, bit 10 of the immediate is ignored
  always_comb begin
    case (op)
      OP_ADDI: begin
        result = A + imm;
      end
      OP_SLTI: begin
        result = {31'b0, $signed(A) < $signed(imm)};
      end
      OP_SLTIU: begin
        result = {31'b0, A < imm};
      end
      OP_XORI: begin
        result = A ^ imm;
      end
      OP_ORI: begin
        result = A | imm;
      end
      OP_ANDI: begin
        result = A & imm;
      end
      OP_SLLI: begin
        result = A << shamt;
      end
      OP_SRLI: begin
        result = A >> shamt;
      end
      OP_SRAI: begin
        result = $signed(A) >>> shamt;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* design/alu_imm_pipeline.sv */
/*
  Immediate ALU lane: issue register, PRF read request, operand
  select, writeback register and the global stall control
*/
module alu_imm_pipeline #(
  parameter int PRF_BANK_COUNT = core_types_pkg::DEF_PRF_BANK_COUNT,
  parameter int PR_COUNT       = core_types_pkg::DEF_PR_COUNT
) (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  logic                                        issue_valid,
  input  core_types_pkg::issue_t                      issue,
  output logic                                        issue_ready,
  output logic                                        read_en,
  output logic [$clog2(PR_COUNT)-1:0]                 read_PR,
  input  core_types_pkg::word_t                       read_data,
  input  core_types_pkg::word_t [PRF_BANK_COUNT-1:0]  forward_data_by_bank,
  input  logic                                        WB_ready,
  output logic                                        WB_valid,
  output core_types_pkg::wb_t                         wb
);
  import core_types_pkg::*;

  logic   advance;
  logic   s1_valid;
  issue_t s1_issue;
  logic   s2_valid;
  issue_t s2_issue;
  word_t  s2_forward_data;
  word_t  operand_a;
  word_t  alu_result;

  // Whole lane moves together whenever WB is free or draining
  assign advance     = ~WB_valid | WB_ready;
  assign issue_ready = advance;

  // S1
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s1_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= issue_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance && issue_valid) begin
      s1_issue <= issue;
    end
  end

  // Read data lands together with S2 since both load on advance
  assign read_en = advance;
  assign read_PR = s1_issue.A_PR;

  alu_imm_operand_collect #(
    .PRF_BANK_COUNT(PRF_BANK_COUNT)
  ) u_operand_collect (
    .CLK                 (CLK),
    .nRST                (nRST),
    .advance             (advance),
    .in_valid            (s1_valid),
    .in_issue            (s1_issue),
    .forward_data_by_bank(forward_data_by_bank),
    .out_valid           (s2_valid),
    .out_issue           (s2_issue),
    .A_forward_data      (s2_forward_data)
  );

  always_comb begin
    if (s2_issue.A_is_zero) begin
      operand_a = '0;
    end else if (s2_issue.A_forward) begin
      operand_a = s2_forward_data;
    end else begin
      operand_a = read_data;
    end
  end

  imm_alu u_imm_alu (
    .op    (s2_issue.op),
    .A     (operand_a),
    .imm12 (s2_issue.imm12),
    .result(alu_result)
  );

  // WB
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      WB_valid <= 1'b0;
    end else if (advance) begin
      WB_valid <= s2_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance && s2_valid) begin
      wb.data      <= alu_result;
      wb.PR        <= s2_issue.dest_PR;
      wb.ROB_index <= s2_issue.ROB_index;
    end
  end

endmodule

/* design/alu_imm_subsystem.sv */
/*
  Top level: immediate ALU lane next to the banked PRF
*/
module alu_imm_subsystem #(
  parameter int PRF_BANK_COUNT = core_types_pkg::DEF_PRF_BANK_COUNT,
  parameter int PR_COUNT       = core_types_pkg::DEF_PR_COUNT
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   issue_valid,
  input  core_types_pkg::issue_t issue,
  output logic                   issue_ready,
  input  logic                   WB_ready,
  output logic                   WB_valid,
  output core_types_pkg::wb_t    wb
);
  import core_types_pkg::*;

  logic                          read_en;
  logic [$clog2(PR_COUNT)-1:0]   read_PR;
  word_t                         read_data;
  word_t [PRF_BANK_COUNT-1:0]    forward_data_by_bank;

  alu_imm_pipeline #(
    .PRF_BANK_COUNT(PRF_BANK_COUNT),
    .PR_COUNT      (PR_COUNT)
  ) u_pipeline (
    .CLK                 (CLK),
    .nRST                (nRST),
    .issue_valid         (issue_valid),
    .issue               (issue),
    .issue_ready         (issue_ready),
    .read_en             (read_en),
    .read_PR             (read_PR),
    .read_data           (read_data),
    .forward_data_by_bank(forward_data_by_bank),
    .WB_ready            (WB_ready),
    .WB_valid            (WB_valid),
    .wb                  (wb)
  );

  // Writes happen on an accepted writeback only
  prf_banks #(
    .PRF_BANK_COUNT(PRF_BANK_COUNT),
    .PR_COUNT      (PR_COUNT)
  ) u_prf (
    .CLK                 (CLK),
    .nRST                (nRST),
    .read_en             (read_en),
    .read_PR             (read_PR),
    .read_data           (read_data),
    .write_en            (WB_valid & WB_ready),
    .write_PR            (wb.PR),
    .write_data          (wb.data),
    .forward_data_by_bank(forward_data_by_bank)
  );

endmodule

/* sim/alu_imm_tests.svh */
/*
  Directed tests of the immediate ALU lane, the reference
  model and the issue helpers they share
*/

task automatic model_issue(issue_t ins);
  word_t a;
  word_t imm;
  word_t r;
  wb_t   exp;
  logic [4:0] sh;
  a   = ins.A_is_zero ? 32'd0 : model_prf[ins.A_PR];
  imm = {{20{ins.imm12[11]}}, ins.imm12};
  sh  = ins.imm12[4:0];
  case (ins.op)
    OP_ADDI:  r = a + imm;
    OP_SLTI:  r = (a[31] != imm[31]) ? {31'b0, a[31]} : {31'b0, a < imm};
    OP_SLTIU: r = {31'b0, a < imm};
    OP_XORI:  r = a ^ imm;
    OP_ORI:   r = a | imm;
    OP_ANDI:  r = a & imm;
    OP_SLLI:  r = a << sh;
    OP_SRLI:  r = a >> sh;
    OP_SRAI:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
    default:  r = '0;
  endcase
  model_prf[ins.dest_PR] = r;
  exp.data      = r;
  exp.PR        = ins.dest_PR;
  exp.ROB_index = ins.ROB_index;
  exp_q.push_back(exp);
endtask

// Caller sits just after a rising edge; returns after the accepting edge
task automatic send_issue(issue_t ins);
  int   n;
  logic taken;
  n     = 0;
  taken = 1'b0;
  issue_valid <= 1'b1;
  issue       <= ins;
  while (!taken) begin
    if (n >= WAIT_LIMIT) begin
      report_timeout("issue was never accepted");
    end
    @(negedge CLK);
    taken = issue_ready;
    @(posedge CLK);
    n++;
  end
endtask

task automatic end_issue();
  issue_valid <= 1'b0;
endtask

task automatic send_op(alu_op_t op, imm12_t imm, logic fwd, logic zero, pr_t a_pr, pr_t dest);
  issue_t ins;
  ins.op        = op;
  ins.imm12     = imm;
  ins.A_forward = fwd;
  ins.A_is_zero = zero;
  ins.A_PR      = a_pr;
  ins.dest_PR   = dest;
  ins.ROB_index = next_rob;
  next_rob      = next_rob + rob_idx_t'(1);
  last_issue    = ins;
  model_issue(ins);
  send_issue(ins);
endtask

function automatic pr_t alloc_pr();
  pr_t pr;
  pr      = next_pr;
  next_pr = next_pr + pr_t'(1);
  return pr;
endfunction

function automatic imm12_t rand_imm();
  return imm12_t'($random(seed));
endfunction

function automatic alu_op_t op_by_index(int i);
  case (i)
    0: return OP_ADDI;
    1: return OP_SLTI;
    2: return OP_SLTIU;
    3: return OP_XORI;
    4: return OP_ORI;
    5: return OP_ANDI;
    6: return OP_SLLI;
    7: return OP_SRLI;
    default: return OP_SRAI;
  endcase
endfunction

task automatic test_reset_and_latency();
  int lat;
  cur_test = "reset_and_latency";
  @(negedge CLK);
  check({cur_test, " WB_valid"}, 32'd0, 32'(WB_valid));
  check({cur_test, " issue_ready"}, 32'd1, 32'(issue_ready));
  @(posedge CLK);
  send_op(OP_ADDI, 12'h9a5, 1'b0, 1'b1, '0, alloc_pr());
  end_issue();
  wait_wb_valid(lat);
  check({cur_test, " latency"}, 32'd3, lat);
  check({cur_test, " direct data"}, 32'hffff_f9a5, wb.data);
  check({cur_test, " direct PR"}, 32'(last_issue.dest_PR), 32'(wb.PR));
  check({cur_test, " direct ROB"}, 32'(last_issue.ROB_index), 32'(wb.ROB_index));
  wait_drain();
endtask

task automatic test_all_ops();
  pr_t src;
  cur_test = "all_ops";
  for (int iter = 0; iter < 3; iter++) begin
    @(posedge CLK);
    src = alloc_pr();
    send_op(OP_ADDI, rand_imm(), 1'b0, 1'b1, '0, src);
    end_issue();
    wait_drain();
    @(posedge CLK);
    for (int k = 0; k < 9; k++) begin
      send_op(op_by_index(k), rand_imm(), 1'b0, 1'b0, src, alloc_pr());
    end
    end_issue();
    wait_drain();
  end
  // Small positive against a negative immediate, and a full-width shift
  @(posedge CLK);
  src = alloc_pr();
  send_op(OP_ADDI, 12'd5, 1'b0, 1'b1, '0, src);
  end_issue();
  wait_drain();
  @(posedge CLK);
  send_op(OP_SLTIU, 12'hfff, 1'b0, 1'b0, src, alloc_pr());
  send_op(OP_SLTI, 12'hfff, 1'b0, 1'b0, src, alloc_pr());
  send_op(OP_ADDI, 12'h800, 1'b0, 1'b1, '0, src);
  end_issue();
  wait_drain();
  @(posedge CLK);
  send_op(OP_SRAI, 12'h01f, 1'b0, 1'b0, src, alloc_pr());
  send_op(OP_SRLI, 12'h41f, 1'b0, 1'b0, src, alloc_pr());
  send_op(OP_SLLI, 12'h404, 1'b0, 1'b0, src, alloc_pr());
  end_issue();
  wait_drain();
endtask

task automatic test_stall();
  int  lat;
  int  hold;
  wb_t snap;
  cur_test = "stall";
  @(posedge CLK);
  WB_ready <= 1'b0;
  send_op(OP_ADDI, rand_imm(), 1'b0, 1'b1, '0, alloc_pr());
  send_op(OP_XORI, rand_imm(), 1'b0, 1'b0, last_issue.dest_PR - 6'd1, alloc_pr());
  send_op(OP_SRAI, 12'h403, 1'b0, 1'b1, '0, alloc_pr());
  end_issue();
  wait_wb_valid(lat);
  // First of the three reaches WB two issues ahead of the last one
  check({cur_test, " first writeback"}, 32'd1, lat);
  snap = wb;
  hold = 2 + ($random(seed) & 7);
  for (int i = 0; i < hold; i++) begin
    @(posedge CLK);
    @(negedge CLK);
    check({cur_test, " WB_valid held"}, 32'd1, 32'(WB_valid));
    check({cur_test, " issue_ready low"}, 32'd0, 32'(issue_ready));
    check({cur_test, " data held"}, snap.data, wb.data);
    check({cur_test, " PR held"}, 32'(snap.PR), 32'(wb.PR));
    check({cur_test, " ROB held"}, 32'(snap.ROB_index), 32'(wb.ROB_index));
  end
  @(posedge CLK);
  WB_ready <= 1'b1;
  wait_drain();
endtask

task automatic test_forward();
  pr_t prod;
  cur_test = "forward";
  for (int i = 0; i < 2; i++) begin
    @(posedge CLK);
    // Producer of pass i lands in bank i
    if (next_pr[0] != i[0]) begin
      void'(alloc_pr());
    end
    prod = alloc_pr();
    send_op(OP_ADDI, rand_imm(), 1'b0, 1'b1, '0, prod);
    send_op(OP_ORI, rand_imm(), 1'b1, 1'b0, prod, alloc_pr());
    end_issue();
    wait_drain();
  end
endtask

task automatic test_back_to_back();
  pr_t src;
  cur_test = "back_to_back";
  @(posedge CLK);
  src = alloc_pr();
  send_op(OP_ADDI, rand_imm(), 1'b0, 1'b1, '0, src);
  end_issue();
  wait_drain();
  prev_wb_cycle = -1;
  burst_check   = 1'b1;
  @(posedge CLK);
  for (int k = 0; k < 8; k++) begin
    send_op(op_by_index(($random(seed) & 32'h7fff_ffff) % 9), rand_imm(), 1'b0,
            logic'($random(seed) & 1), src, alloc_pr());
  end
  end_issue();
  wait_drain();
  burst_check = 1'b0;
endtask

/* sim/alu_imm_tb.sv */
/*
  Testbench for the immediate ALU lane: clock, reset, DUT,
  writeback monitor, value check, wait loops and closing report
*/
module alu_imm_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import core_types_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic   CLK;
  logic   nRST;
  logic   issue_valid;
  issue_t issue;
  logic   issue_ready;
  logic   WB_ready;
  logic   WB_valid;
  wb_t    wb;

  int     seed = 12;
  int     check_count;
  int     error_count;
  int     timeout_count;
  int     cycle_no;
  int     prev_wb_cycle;
  logic   burst_check;
  string  cur_test;

  // Scoreboard state
  word_t    model_prf [DEF_PR_COUNT];
  wb_t      exp_q [$];
  pr_t      next_pr;
  rob_idx_t next_rob;
  issue_t   last_issue;

  alu_imm_subsystem #(
    .PRF_BANK_COUNT(DEF_PRF_BANK_COUNT),
    .PR_COUNT      (DEF_PR_COUNT)
  ) UUT (
    .CLK        (CLK),
    .nRST       (nRST),
    .issue_valid(issue_valid),
    .issue      (issue),
    .issue_ready(issue_ready),
    .WB_ready   (WB_ready),
    .WB_valid   (WB_valid),
    .wb         (wb)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_no <= cycle_no + 1;
  end

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d, timeouts: %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  task automatic report_timeout(string what);
    $display("TIMEOUT in %s: %s", cur_test, what);
    timeout_count++;
    finish_run();
  endtask

  task automatic check(string name, word_t expected, word_t actual);
    check_count++;
    if (expected !== actual) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  // Every accepted writeback is matched against the oldest expected one
  task automatic take_writeback();
    wb_t exp;
    if (exp_q.size() == 0) begin
      $display("ERROR in %s: writeback to PR %0d with nothing outstanding", cur_test, wb.PR);
      error_count++;
    end else begin
      exp = exp_q.pop_front();
      check({cur_test, " data"}, exp.data, wb.data);
      check({cur_test, " PR"}, 32'(exp.PR), 32'(wb.PR));
      check({cur_test, " ROB_index"}, 32'(exp.ROB_index), 32'(wb.ROB_index));
    end
    if (burst_check && prev_wb_cycle >= 0) begin
      check({cur_test, " writeback spacing"}, 32'd1, cycle_no - prev_wb_cycle);
    end
    prev_wb_cycle = cycle_no;
  endtask

  always @(negedge CLK) begin
    if (nRST && WB_valid && WB_ready) begin
      take_writeback();
    end
  end

  // Counts cycles after the acceptance edge until WB_valid is seen
  task automatic wait_wb_valid(output int cycles);
    int n;
    n = 1;
    @(negedge CLK);
    while (!WB_valid) begin
      if (n >= WAIT_LIMIT) begin
        report_timeout("WB_valid never went high");
      end
      @(posedge CLK);
      n++;
      @(negedge CLK);
    end
    cycles = n;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge CLK);
    while (exp_q.size() != 0) begin
      if (n >= WAIT_LIMIT) begin
        report_timeout("writebacks still outstanding");
      end
      @(negedge CLK);
      n++;
    end
  endtask

  `include "alu_imm_tests.svh"

  initial begin
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    cycle_no      = 0;
    prev_wb_cycle = -1;
    burst_check   = 1'b0;
    next_pr       = '0;
    next_rob      = '0;
    cur_test      = "reset";
    for (int i = 0; i < DEF_PR_COUNT; i++) begin
      model_prf[i] = '0;
    end
    nRST        <= 1'b0;
    issue_valid <= 1'b0;
    issue       <= '0;
    WB_ready    <= 1'b1;
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);

    test_reset_and_latency();
    test_all_ops();
    test_stall();
    test_forward();
    test_back_to_back();
    finish_run();
  end

endmodule

/* src.f */
design/core_types_pkg.sv
design/prf_banks.sv
design/alu_imm_operand_collect.sv
design/imm_alu.sv
design/alu_imm_pipeline.sv
design/alu_imm_subsystem.sv
+incdir+sim
sim/alu_imm_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the immediate ALU lane testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module alu_imm_tb -f src.f -o alu_imm_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/alu_imm_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
